// ==== all.f ====
+incdir+src
src/acq_bus_pkg.sv
src/acq_data_pkg.sv
src/acq_sample_source.sv
src/acq_prefetch_fifo.sv
src/acq_regs.sv
src/acq_top.sv
verif/acq_tb_clk.sv
verif/acq_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the acquisition testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   --top-module acq_tb -f all.f -o acq_tb_sim
# A failed check ends in $fatal, which gives a nonzero exit status
./obj_dir/acq_tb_sim

// ==== src/acq_bus_pkg.sv ====
`include "acq_params.svh"

package acq_bus_pkg;

   // ------------------------------
   // APB bundles
   // ------------------------------
   // Host to slave, setup then access phase
   typedef struct packed {
      logic                   psel;
      logic                   penable;
      logic                   pwrite;
      logic [`ACQ_ADDR_W-1:0] paddr;
      logic [`ACQ_DATA_W-1:0] pwdata;
   } apb_req_t;

   // Slave to host
   typedef struct packed {
      logic                   pready;
      logic [`ACQ_DATA_W-1:0] prdata;
      logic                   pslverr;
   } apb_rsp_t;

   // Register addresses, 4 and 5 left unmapped
   typedef enum logic [`ACQ_ADDR_W-1:0] {
      REG_STREAM = `ACQ_REG_STREAM,
      REG_DATA1  = `ACQ_REG_DATA1,
      REG_DATA2  = `ACQ_REG_DATA2,
      REG_DATA3  = `ACQ_REG_DATA3,
      REG_DEBUG  = `ACQ_REG_DEBUG,
      REG_STATUS = `ACQ_REG_STATUS
   } acq_reg_e;

endpackage

// ==== src/acq_data_pkg.sv ====
`include "acq_params.svh"

package acq_data_pkg;

   // Acquisition control, from the register block
   typedef struct packed {
      logic       enabled;
      logic       debug;
      logic [2:0] delay;
   } acq_ctrl_t;

   // One antenna sample word
   typedef logic [`ACQ_SAMPLE_W-1:0] acq_sample_t;

   // Sample source FSM
   typedef enum logic [1:0] {
      SRC_IDLE = 2'd0,
      SRC_WAIT = 2'd1,
      SRC_PUSH = 2'd2
   } src_state_e;

endpackage

// ==== src/acq_params.svh ====
`ifndef ACQ_PARAMS_SVH
`define ACQ_PARAMS_SVH

// ------------------------------
// Bus and sample widths
// ------------------------------
// APB data bus, one byte per transfer
`define ACQ_DATA_W      8
`define ACQ_ADDR_W      3
// Antenna sample, three bytes
`define ACQ_SAMPLE_W    24

// Prefetch FIFO entries
`define ACQ_FIFO_DEPTH  4

// ------------------------------
// Register map
// ------------------------------
`define ACQ_REG_STREAM  3'd0
`define ACQ_REG_DATA1   3'd1
`define ACQ_REG_DATA2   3'd2
`define ACQ_REG_DATA3   3'd3
`define ACQ_REG_DEBUG   3'd6
`define ACQ_REG_STATUS  3'd7

`endif

// ==== src/acq_prefetch_fifo.sv ====
`timescale 1ns/10ps
`include "acq_params.svh"

module acq_prefetch_fifo
   import acq_data_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        wr_valid_i,
   input  acq_sample_t wr_data_i,
   output logic        wr_ready_o,
   output logic        rd_valid_o,
   output acq_sample_t rd_data_o,
   input  logic        rd_ready_i,
   output logic        full_o
);

   localparam int DEPTH = `ACQ_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   acq_sample_t      mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   // Handshakes on both sides
   assign full_o     = (count_q == CNT_W'(DEPTH));
   assign wr_ready_o = !full_o;
   assign rd_valid_o = (count_q != '0);
   assign push       = wr_valid_i && wr_ready_o;
   assign pop        = rd_valid_o && rd_ready_i;

   // Head entry shown without popping
   assign rd_data_o  = mem_q[rd_ptr_q];

   // Storage
   always_ff @(posedge clk_i) begin
      if (push)
         mem_q[wr_ptr_q] <= wr_data_i;
   end

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         // Simultaneous push and pop leaves count unchanged
         if (push && !pop)
            count_q <= count_q + 1'b1;
         else if (pop && !push)
            count_q <= count_q - 1'b1;
      end
   end

endmodule

// ==== src/acq_regs.sv ====
`timescale 1ns/10ps
`include "acq_params.svh"

module acq_regs
   import acq_bus_pkg::*, acq_data_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  apb_req_t    apb_req_i,
   output apb_rsp_t    apb_rsp_o,
   output acq_ctrl_t   ctrl_o,
   input  logic        rd_valid_i,
   input  acq_sample_t rd_data_i,
   output logic        rd_ready_o,
   input  logic        full_i
);

   localparam int DW = `ACQ_DATA_W;

   acq_ctrl_t   ctrl_q;
   acq_reg_e    addr;
   logic        access;
   logic        wr_en;
   logic        rd_en;
   logic        bad_addr;
   logic        stream_rd;
   logic [1:0]  idx_q;
   acq_sample_t head;
   logic [DW-1:0] byte_hi;
   logic [DW-1:0] byte_mid;
   logic [DW-1:0] byte_lo;
   logic [DW-1:0] stream_byte;
   logic [DW-1:0] debug_val;
   logic [DW-1:0] status_val;
   logic [DW-1:0] rdata;

   // ------------------------------
   // APB access decode
   // ------------------------------
   assign addr   = acq_reg_e'(apb_req_i.paddr);
   // Access phase, no wait states
   assign access = apb_req_i.psel && apb_req_i.penable;
   assign wr_en  = access && apb_req_i.pwrite;
   assign rd_en  = access && !apb_req_i.pwrite;

   // Unmapped addresses 4 and 5
   always_comb begin
      case (addr)
         REG_STREAM, REG_DATA1, REG_DATA2, REG_DATA3,
         REG_DEBUG, REG_STATUS: bad_addr = 1'b0;
         default:               bad_addr = 1'b1;
      endcase
   end

   // ------------------------------
   // Antenna data bytes
   // ------------------------------
   // Zero when nothing buffered
   assign head     = rd_valid_i ? rd_data_i : '0;
   assign byte_hi  = head[2*DW +: DW];
   assign byte_mid = head[DW +: DW];
   assign byte_lo  = head[0 +: DW];

   // MSB first across the stream index
   always_comb begin
      case (idx_q)
         2'd0:    stream_byte = byte_hi;
         2'd1:    stream_byte = byte_mid;
         default: stream_byte = byte_lo;
      endcase
   end

   // Stream read only counts with data present
   assign stream_rd  = rd_en && (addr == REG_STREAM) && rd_valid_i;
   // Third byte pops the head at the end of the access
   assign rd_ready_o = stream_rd && (idx_q == 2'd2);

   always_ff @(posedge clk_i) begin
      if (rst_i)
         idx_q <= '0;
      else if (stream_rd)
         idx_q <= (idx_q == 2'd2) ? 2'd0 : idx_q + 2'd1;
   end

   // ------------------------------
   // Control registers
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ctrl_q <= '0;
      end else if (wr_en) begin
         case (addr)
            REG_DEBUG: begin
               ctrl_q.debug <= apb_req_i.pwdata[7];
               ctrl_q.delay <= apb_req_i.pwdata[2:0];
            end
            REG_STATUS: ctrl_q.enabled <= apb_req_i.pwdata[0];
            default: ;
         endcase
      end
   end

   assign ctrl_o = ctrl_q;

   // Debug bit on top, delay in the low bits
   assign debug_val  = {ctrl_q.debug, 4'b0, ctrl_q.delay};
   // Enabled, data available, FIFO full
   assign status_val = {5'b0, full_i, rd_valid_i, ctrl_q.enabled};

   // ------------------------------
   // Read mux and response
   // ------------------------------
   always_comb begin
      case (addr)
         REG_STREAM: rdata = stream_byte;
         REG_DATA1:  rdata = byte_hi;
         REG_DATA2:  rdata = byte_mid;
         REG_DATA3:  rdata = byte_lo;
         REG_DEBUG:  rdata = debug_val;
         REG_STATUS: rdata = status_val;
         default:    rdata = '0;
      endcase
   end

   always_comb begin
      apb_rsp_o.pready  = access;
      apb_rsp_o.prdata  = rd_en ? rdata : '0;
      apb_rsp_o.pslverr = access && bad_addr;
   end

endmodule

// ==== src/acq_sample_source.sv ====
`timescale 1ns/10ps

module acq_sample_source
   import acq_data_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  acq_ctrl_t   ctrl_i,
   input  acq_sample_t ext_sample_i,
   output logic        wr_valid_o,
   output acq_sample_t wr_data_o,
   input  logic        wr_ready_i
);

   src_state_e  state_q;
   logic [2:0]  wait_cnt_q;
   acq_sample_t dbg_cnt_q;
   acq_sample_t sample_q;
   logic        wait_done;
   logic        push_done;

   // Delay elapsed, counts delay+1 cycles in SRC_WAIT
   assign wait_done  = (state_q == SRC_WAIT) && ctrl_i.enabled &&
                       (wait_cnt_q >= ctrl_i.delay);
   assign wr_valid_o = (state_q == SRC_PUSH);
   assign push_done  = wr_valid_o && wr_ready_i;

   // ------------------------------
   // Pacing FSM
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q    <= SRC_IDLE;
         wait_cnt_q <= '0;
      end else begin
         case (state_q)
            SRC_IDLE: begin
               if (ctrl_i.enabled) begin
                  state_q    <= SRC_WAIT;
                  wait_cnt_q <= '0;
               end
            end
            SRC_WAIT: begin
               if (!ctrl_i.enabled)
                  state_q <= SRC_IDLE;
               else if (wait_done)
                  state_q <= SRC_PUSH;
               else
                  wait_cnt_q <= wait_cnt_q + 3'd1;
            end
            SRC_PUSH: begin
               // Stall here while FIFO is full, finish push before idling
               if (wr_ready_i) begin
                  state_q    <= ctrl_i.enabled ? SRC_WAIT : SRC_IDLE;
                  wait_cnt_q <= '0;
               end
            end
            default: state_q <= SRC_IDLE;
         endcase
      end
   end

   // ------------------------------
   // Sample values
   // ------------------------------
   // Debug pattern, steps once per accepted push
   always_ff @(posedge clk_i) begin
      if (rst_i)
         dbg_cnt_q <= '0;
      else if (push_done && ctrl_i.debug)
         dbg_cnt_q <= dbg_cnt_q + 1'b1;
   end

   // Front-end sample latched on entry to SRC_PUSH
   always_ff @(posedge clk_i) begin
      if (wait_done)
         sample_q <= ext_sample_i;
   end

   assign wr_data_o = ctrl_i.debug ? dbg_cnt_q : sample_q;

endmodule

// ==== src/acq_top.sv ====
`timescale 1ns/10ps

module acq_top
   import acq_bus_pkg::*, acq_data_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  apb_req_t    apb_req_i,
   output apb_rsp_t    apb_rsp_o,
   input  acq_sample_t ext_sample_i
);

   // Control from registers to source
   acq_ctrl_t   ctrl;
   // Source to FIFO
   logic        wr_valid;
   logic        wr_ready;
   acq_sample_t wr_data;
   // FIFO to register block
   logic        rd_valid;
   logic        rd_ready;
   acq_sample_t rd_data;
   logic        full;

   acq_sample_source u_source (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .ctrl_i       (ctrl),
      .ext_sample_i (ext_sample_i),
      .wr_valid_o   (wr_valid),
      .wr_data_o    (wr_data),
      .wr_ready_i   (wr_ready)
   );

   acq_prefetch_fifo u_fifo (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .wr_valid_i (wr_valid),
      .wr_data_i  (wr_data),
      .wr_ready_o (wr_ready),
      .rd_valid_o (rd_valid),
      .rd_data_o  (rd_data),
      .rd_ready_i (rd_ready),
      .full_o     (full)
   );

   acq_regs u_regs (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .apb_req_i  (apb_req_i),
      .apb_rsp_o  (apb_rsp_o),
      .ctrl_o     (ctrl),
      .rd_valid_i (rd_valid),
      .rd_data_i  (rd_data),
      .rd_ready_o (rd_ready),
      .full_i     (full)
   );

endmodule

// ==== verif/acq_tb.sv ====
`timescale 1ns/10ps

module acq_tb
   import acq_bus_pkg::*, acq_data_pkg::*;
();

   // Limit well above the roughly 600 cycles the tests take
   localparam int TIMEOUT_CYCLES = 4000;

   logic        clk;
   logic        rst;
   apb_req_t    req;
   apb_rsp_t    rsp;
   acq_sample_t ext_sample;
   integer      seed = 23;
   int unsigned cycle_cnt = 0;

   // Model of the captured front-end samples
   acq_sample_t exp_q [$];
   acq_sample_t ext_seen = '0;
   acq_sample_t captured = '0;
   logic        valid_seen = 1'b0;

   acq_tb_clk u_clk (
      .clk_o (clk),
      .rst_o (rst)
   );

   acq_top u_acq_top (
      .clk_i        (clk),
      .rst_i        (rst),
      .apb_req_i    (req),
      .apb_rsp_o    (rsp),
      .ext_sample_i (ext_sample)
   );

   // ------------------------------
   // Failure reporting
   // ------------------------------
   task automatic report_failure(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1, "acq_tb stopped on a failed check");
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                  input logic [31:0] got_val);
      report_failure($sformatf("Error %s expected %h got %h", sig, exp_val, got_val));
   endtask

   // Run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         report_failure("Timeout, the tests did not finish within the cycle limit");
   end

   // New front-end input drawn every cycle
   always @(posedge clk) begin
      ext_sample <= acq_sample_t'($random(seed));
   end

   // ------------------------------
   // Sample model
   // ------------------------------
   // Sampled mid-cycle where ext_seen is what the next edge latches
   always @(negedge clk) begin
      // Entry to the push state captures the previous cycle's input
      if (u_acq_top.wr_valid && !valid_seen)
         captured = ext_seen;
      // Accepted at the coming edge
      if (u_acq_top.wr_valid && u_acq_top.wr_ready && !u_acq_top.ctrl.debug)
         exp_q.push_back(captured);
      valid_seen = u_acq_top.wr_valid;
      ext_seen   = ext_sample;
   end

   // Ready in every access phase and nowhere else
   a_pready: assert property (@(posedge clk)
      rsp.pready == (req.psel && req.penable))
      else report_mismatch("pready", $sampled(req.psel && req.penable),
                           $sampled(rsp.pready));

   // Slave error only for the unmapped addresses
   a_pslverr: assert property (@(posedge clk)
      rsp.pslverr == (req.psel && req.penable && (req.paddr == 3'd4 || req.paddr == 3'd5)))
      else report_mismatch("pslverr",
                           $sampled(req.psel && req.penable &&
                                    (req.paddr == 3'd4 || req.paddr == 3'd5)),
                           $sampled(rsp.pslverr));

   // ------------------------------
   // APB tasks
   // ------------------------------
   task automatic apb_write(input logic [2:0] addr, input logic [7:0] data);
      @(posedge clk);
      req.psel    <= 1'b1;
      req.penable <= 1'b0;
      req.pwrite  <= 1'b1;
      req.paddr   <= addr;
      req.pwdata  <= data;
      @(posedge clk);
      req.penable <= 1'b1;
      // Write lands on this edge
      @(posedge clk);
      req <= '0;
   endtask

   task automatic apb_read(input logic [2:0] addr, output logic [7:0] data,
                           output logic err);
      @(posedge clk);
      req.psel    <= 1'b1;
      req.penable <= 1'b0;
      req.pwrite  <= 1'b0;
      req.paddr   <= addr;
      req.pwdata  <= '0;
      @(posedge clk);
      req.penable <= 1'b1;
      // Middle of the access phase
      @(negedge clk);
      data = rsp.prdata;
      err  = rsp.pslverr;
      @(posedge clk);
      req <= '0;
   endtask

   task automatic check_read(input logic [2:0] addr, input logic [7:0] exp_val);
      logic [7:0] data;
      logic       err;
      apb_read(addr, data, err);
      assert (data == exp_val)
         else report_mismatch("prdata", exp_val, data);
   endtask

   task automatic check_slverr(input logic [2:0] addr);
      logic [7:0] data;
      logic       err;
      apb_read(addr, data, err);
      assert (err)
         else report_mismatch("pslverr", 1, err);
   endtask

   task automatic read_status(output logic [7:0] st);
      logic err;
      apb_read(REG_STATUS, st, err);
   endtask

   // Poll until a status bit is set
   task automatic wait_status(input int bit_idx);
      logic [7:0] st;
      do
         read_status(st);
      while (!st[bit_idx]);
   endtask

   // ------------------------------
   // Sample helpers
   // ------------------------------
   // Three stream reads with the MSB first
   task automatic stream_expected(input acq_sample_t exp_val);
      check_read(REG_STREAM, exp_val[23:16]);
      check_read(REG_STREAM, exp_val[15:8]);
      check_read(REG_STREAM, exp_val[7:0]);
   endtask

   task automatic pop_expected(output acq_sample_t val);
      if (exp_q.size() == 0)
         report_failure("FIFO returned a sample that the model never saw pushed");
      else
         val = exp_q.pop_front();
   endtask

   // Empty the FIFO and compare with the model when asked
   task automatic drain(input logic check);
      logic [7:0]  st;
      logic [7:0]  data;
      logic        err;
      acq_sample_t val;
      read_status(st);
      while (st[1]) begin
         if (check) begin
            pop_expected(val);
            stream_expected(val);
         end else begin
            repeat (3) apb_read(REG_STREAM, data, err);
         end
         read_status(st);
      end
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      logic [7:0]  st;
      acq_sample_t val;
      req        = '0;
      ext_sample = '0;
      wait (rst === 1'b0);

      // Reset values
      check_read(REG_STATUS, 8'h00);
      check_read(REG_STREAM, 8'h00);

      // Debug on with delay 5 and then the unmapped addresses
      apb_write(REG_DEBUG, 8'h85);
      check_read(REG_DEBUG, 8'h85);
      check_slverr(3'd4);
      check_slverr(3'd5);

      // Counting pattern once the FIFO has filled
      apb_write(REG_STATUS, 8'h01);
      wait_status(2);
      for (int i = 0; i < 4; i++)
         stream_expected(acq_sample_t'(i));

      // Byte registers show count 4 without popping it
      check_read(REG_DATA1, 8'h00);
      check_read(REG_DATA2, 8'h00);
      check_read(REG_DATA3, 8'h04);
      repeat (2) begin
         read_status(st);
         assert (st[1])
            else report_mismatch("status_rd_valid", 1, st[1]);
      end
      stream_expected(acq_sample_t'(4));

      // Stopped source leaves the drained FIFO empty
      apb_write(REG_STATUS, 8'h00);
      drain(1'b0);
      repeat (20) @(posedge clk);
      check_read(REG_STATUS, 8'h00);

      // Sampled input with delay 2
      apb_write(REG_DEBUG, 8'h02);
      assert (exp_q.size() == 0)
         else report_failure("Model saw a push while the source was stopped");
      apb_write(REG_STATUS, 8'h01);
      wait_status(1);
      val = exp_q[0];
      check_read(REG_DATA1, val[23:16]);
      check_read(REG_DATA2, val[15:8]);
      check_read(REG_DATA3, val[7:0]);
      for (int i = 0; i < 3; i++) begin
         wait_status(1);
         pop_expected(val);
         stream_expected(val);
      end

      // Long pause stalls the source on a full FIFO
      repeat (150) @(posedge clk);
      read_status(st);
      assert (st[2])
         else report_mismatch("status_full", 1, st[2]);
      for (int i = 0; i < 10; i++) begin
         wait_status(1);
         pop_expected(val);
         stream_expected(val);
      end

      // Every modelled sample comes out after the stop
      apb_write(REG_STATUS, 8'h00);
      drain(1'b1);
      assert (exp_q.size() == 0)
         else report_failure("Model holds samples that never came out of the FIFO");
      repeat (20) @(posedge clk);
      check_read(REG_STATUS, 8'h00);

      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== verif/acq_tb_clk.sv ====
`timescale 1ns/10ps

module acq_tb_clk (
   output logic clk_o,
   output logic rst_o
);

   // 40 ns period
   initial begin
      clk_o = 1'b0;
      forever #20 clk_o = ~clk_o;
   end

   // Reset held over the first 4 rising edges
   initial begin
      rst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule
